//--- logic/bx_pkg.sv
// Backend package with widths, micro-op and unit codes, operand source bits and instruction union
package bx_pkg;

    // --------------------------------------------------
    // Widths
    localparam int XLEN      = 32;                // Data path width
    localparam int REG_W     = 5;                 // Register address width
    localparam int OPR_SRC_W = 5;                 // Operand source vector width

    // --------------------------------------------------
    // Micro-ops and functional units
    typedef enum logic [3:0] {
        UOP_ADD   = 4'd0,
        UOP_SUB   = 4'd1,
        UOP_AND   = 4'd2,
        UOP_OR    = 4'd3,
        UOP_XOR   = 4'd4,
        UOP_SLL   = 4'd5,
        UOP_SRL   = 4'd6,
        UOP_SRA   = 4'd7,
        UOP_SLT   = 4'd8,
        UOP_SLTU  = 4'd9,
        UOP_PASSB = 4'd10                         // A plus B, A zero except AUIPC
    } uop_e;

    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_NONE = 2'd3                            // Trapped, no unit
    } fu_e;

    // --------------------------------------------------
    // Operand source bit positions
    localparam int DIS_OPRA_RS1  = 0;             // A from rs1
    localparam int DIS_OPRA_PCIM = 1;             // A from PC plus immediate
    localparam int DIS_OPRA_ZERO = 2;             // A held at zero
    localparam int DIS_OPRB_RS2  = 3;             // B from rs2
    localparam int DIS_OPRB_IMM  = 4;             // B from immediate
    localparam int DIS_OPRC_RS2  = DIS_OPRB_RS2;  // C rides on the B rs2 select

    // --------------------------------------------------
    // Opcodes and instruction layouts
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_AUIPC = 7'b0010111;

    typedef struct packed {
        logic [6:0]       funct7;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0]      imm12;
        logic [REG_W-1:0] rs1;
        logic [2:0]       funct3;
        logic [REG_W-1:0] rd;
        logic [6:0]       opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;                              // Register layout
        instr_i_t i;                              // Immediate layout
    } instr_u;

endpackage

//--- logic/bx_gprs.sv
// General purpose register file with two combinational read ports and one write port
`timescale 1ns/10ps
module bx_gprs (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic [bx_pkg::REG_W-1:0] rs1_addr,
    output logic [bx_pkg::XLEN-1:0]  rs1_data,
    input  logic [bx_pkg::REG_W-1:0] rs2_addr,
    output logic [bx_pkg::XLEN-1:0]  rs2_data,
    input  logic                     rd_wen,
    input  logic [bx_pkg::REG_W-1:0] rd_addr,
    input  logic [bx_pkg::XLEN-1:0]  rd_data
);
    import bx_pkg::*;

    logic [XLEN-1:0] regs [0:(1<<REG_W)-1];

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << REG_W); i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin  // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- logic/bx_decode.sv
// Decode stage with instruction field split, micro-op select, immediates and stage register
`timescale 1ns/10ps
module bx_decode (
    input  logic                        g_clk,
    input  logic                        rst_n,
    input  logic                        flush,       // Drop stage contents
    input  logic                        in_valid,
    input  bx_pkg::instr_u              in_instr,
    input  logic [bx_pkg::XLEN-1:0]     in_pc,
    output logic                        in_busy,     // Cannot accept this cycle
    output logic                        s1_valid,
    output logic [bx_pkg::REG_W-1:0]    s1_rd,
    output logic [bx_pkg::REG_W-1:0]    s1_rs1,
    output logic [bx_pkg::REG_W-1:0]    s1_rs2,
    output logic [bx_pkg::XLEN-1:0]     s1_imm,
    output logic [bx_pkg::XLEN-1:0]     s1_pc,
    output bx_pkg::uop_e                s1_uop,
    output bx_pkg::fu_e                 s1_fu,
    output logic                        s1_trap,
    output logic [bx_pkg::OPR_SRC_W-1:0] s1_opr_src,
    input  logic                        s1_busy
);
    import bx_pkg::*;

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 alt;                       // funct7[5] or imm[10]
    logic [XLEN-1:0]      imm_i;
    logic [XLEN-1:0]      imm_u;
    uop_e                 alu_uop;
    uop_e                 n_uop;
    fu_e                  n_fu;
    logic                 n_trap;
    logic [XLEN-1:0]      n_imm;
    logic [OPR_SRC_W-1:0] n_src;

    assign opcode = in_instr.r.opcode;
    assign funct3 = in_instr.r.funct3;
    assign alt    = (opcode == OP_REG) ? in_instr.r.funct7[5] : in_instr.i.imm12[10];
    assign imm_i  = {{(XLEN-12){in_instr.i.imm12[11]}}, in_instr.i.imm12}; // Sign extend
    assign imm_u  = {in_instr.i.imm12, in_instr.i.rs1, in_instr.i.funct3, 12'b0};

    // --------------------------------------------------
    // Micro-op and operand sources
    always_comb begin
        case (funct3)
            3'b000:  alu_uop = (alt && opcode == OP_REG) ? UOP_SUB : UOP_ADD; // No SUBI
            3'b001:  alu_uop = UOP_SLL;
            3'b010:  alu_uop = UOP_SLT;
            3'b011:  alu_uop = UOP_SLTU;
            3'b100:  alu_uop = UOP_XOR;
            3'b101:  alu_uop = alt ? UOP_SRA : UOP_SRL;
            3'b110:  alu_uop = UOP_OR;
            default: alu_uop = UOP_AND;
        endcase
    end

    always_comb begin
        n_uop  = alu_uop;
        n_fu   = FU_ALU;
        n_trap = 1'b0;
        n_imm  = '0;
        n_src  = '0;
        case (opcode)
            OP_REG: begin
                n_src[DIS_OPRA_RS1] = 1'b1;
                n_src[DIS_OPRB_RS2] = 1'b1;
                n_src[DIS_OPRC_RS2] = 1'b1;
            end
            OP_IMM: begin
                n_src[DIS_OPRA_RS1] = 1'b1;
                n_src[DIS_OPRB_IMM] = 1'b1;
                n_imm               = imm_i;
            end
            OP_LUI: begin
                n_src[DIS_OPRA_ZERO] = 1'b1;         // 0 + imm
                n_src[DIS_OPRB_IMM]  = 1'b1;
                n_imm                = imm_u;
                n_uop                = UOP_PASSB;
            end
            OP_AUIPC: begin
                n_src[DIS_OPRA_PCIM] = 1'b1;         // pc+imm, B stays zero
                n_imm                = imm_u;
                n_uop                = UOP_PASSB;
            end
            default: begin
                n_fu   = FU_NONE;                    // Unknown opcode
                n_trap = 1'b1;
            end
        endcase
    end

    // --------------------------------------------------
    // Stage register
    assign in_busy = s1_valid && s1_busy;            // Full and not draining

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (flush) begin
            s1_valid <= 1'b0;
        end else if (!in_busy) begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (in_valid && !in_busy) begin
            s1_rd      <= in_instr.r.rd;
            s1_rs1     <= in_instr.r.rs1;
            s1_rs2     <= in_instr.r.rs2;
            s1_imm     <= n_imm;
            s1_pc      <= in_pc;
            s1_uop     <= n_uop;
            s1_fu      <= n_fu;
            s1_trap    <= n_trap;
            s1_opr_src <= n_src;
        end
    end

endmodule

//--- logic/bx_dispatch.sv
// Dispatch stage with register read, forwarding, PC plus immediate, operand gather and stage register
`timescale 1ns/10ps
module bx_dispatch (
    input  logic                         g_clk,
    input  logic                         rst_n,
    input  logic                         flush,
    input  logic                         s1_valid,
    input  logic [bx_pkg::REG_W-1:0]     s1_rd,
    input  logic [bx_pkg::REG_W-1:0]     s1_rs1,
    input  logic [bx_pkg::REG_W-1:0]     s1_rs2,
    input  logic [bx_pkg::XLEN-1:0]      s1_imm,
    input  logic [bx_pkg::XLEN-1:0]      s1_pc,
    input  bx_pkg::uop_e                 s1_uop,
    input  bx_pkg::fu_e                  s1_fu,
    input  logic                         s1_trap,
    input  logic [bx_pkg::OPR_SRC_W-1:0] s1_opr_src,
    output logic                         s1_busy,
    input  logic [bx_pkg::REG_W-1:0]     fwd_s3_rd,      // Zero when no producer
    input  logic [bx_pkg::XLEN-1:0]      fwd_s3_wdata,
    input  logic [bx_pkg::REG_W-1:0]     fwd_s4_rd,
    input  logic [bx_pkg::XLEN-1:0]      fwd_s4_wdata,
    input  logic                         gpr_wen,
    input  logic [bx_pkg::REG_W-1:0]     gpr_rd,
    input  logic [bx_pkg::XLEN-1:0]      gpr_wdata,
    output logic                         s2_valid,
    output logic [bx_pkg::REG_W-1:0]     s2_rd,
    output logic [bx_pkg::XLEN-1:0]      s2_opr_a,
    output logic [bx_pkg::XLEN-1:0]      s2_opr_b,
    output logic [bx_pkg::XLEN-1:0]      s2_opr_c,
    output logic [bx_pkg::XLEN-1:0]      s2_pc,
    output bx_pkg::uop_e                 s2_uop,
    output logic                         s2_trap,
    input  logic                         s2_busy
);
    import bx_pkg::*;

    logic [XLEN-1:0] rs1_rf;                         // Raw register file reads
    logic [XLEN-1:0] rs2_rf;
    logic [XLEN-1:0] dis_rs1;                        // After forwarding
    logic [XLEN-1:0] dis_rs2;
    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] n_opr_a;
    logic [XLEN-1:0] n_opr_b;
    logic [XLEN-1:0] n_opr_c;
    logic            n_trap;

    // Youngest producer wins, write port bypass covers the retiring instruction
    function automatic logic [XLEN-1:0] fwd_pick(input logic [REG_W-1:0] addr,
                                                 input logic [XLEN-1:0]  rf_data);
        if (addr == '0)
            return rf_data;
        else if (addr == fwd_s3_rd)
            return fwd_s3_wdata;
        else if (addr == fwd_s4_rd)
            return fwd_s4_wdata;
        else if (gpr_wen && addr == gpr_rd)
            return gpr_wdata;
        return rf_data;
    endfunction

    bx_gprs u_gprs (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .rs1_addr (s1_rs1),
        .rs1_data (rs1_rf),
        .rs2_addr (s1_rs2),
        .rs2_data (rs2_rf),
        .rd_wen   (gpr_wen),                         // Write from result stage
        .rd_addr  (gpr_rd),
        .rd_data  (gpr_wdata)
    );

    // --------------------------------------------------
    // Operand gather
    always_comb begin
        dis_rs1 = fwd_pick(s1_rs1, rs1_rf);
        dis_rs2 = fwd_pick(s1_rs2, rs2_rf);
    end
    assign pc_plus_imm = s1_pc + s1_imm;             // AUIPC target

    assign n_opr_a = {XLEN{s1_opr_src[DIS_OPRA_RS1]}}  & dis_rs1     |
                     {XLEN{s1_opr_src[DIS_OPRA_PCIM]}} & pc_plus_imm;
    assign n_opr_b = {XLEN{s1_opr_src[DIS_OPRB_RS2]}}  & dis_rs2     |
                     {XLEN{s1_opr_src[DIS_OPRB_IMM]}}  & s1_imm;
    assign n_opr_c = {XLEN{s1_opr_src[DIS_OPRC_RS2]}}  & dis_rs2;
    assign n_trap  = s1_trap || (s1_fu == FU_NONE);  // No unit takes it

    // --------------------------------------------------
    // Stage register
    assign s1_busy = s2_valid && s2_busy;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (flush) begin
            s2_valid <= 1'b0;
        end else if (!s1_busy) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s1_valid && !s1_busy) begin
            s2_rd    <= s1_rd;
            s2_opr_a <= n_opr_a;
            s2_opr_b <= n_opr_b;
            s2_opr_c <= n_opr_c;
            s2_pc    <= s1_pc;
            s2_uop   <= s1_uop;
            s2_trap  <= n_trap;
        end
    end

endmodule

//--- logic/bx_execute.sv
// Execute stage with ALU, forwarding export and stage register
`timescale 1ns/10ps
module bx_execute (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     s2_valid,
    input  logic [bx_pkg::REG_W-1:0] s2_rd,
    input  logic [bx_pkg::XLEN-1:0]  s2_opr_a,
    input  logic [bx_pkg::XLEN-1:0]  s2_opr_b,
    input  logic [bx_pkg::XLEN-1:0]  s2_opr_c,       // Store data lane, no ALU use
    input  logic [bx_pkg::XLEN-1:0]  s2_pc,
    input  bx_pkg::uop_e             s2_uop,
    input  logic                     s2_trap,
    output logic                     s2_busy,
    output logic [bx_pkg::REG_W-1:0] fwd_s3_rd,
    output logic [bx_pkg::XLEN-1:0]  fwd_s3_wdata,
    output logic                     s3_valid,
    output logic [bx_pkg::REG_W-1:0] s3_rd,
    output logic [bx_pkg::XLEN-1:0]  s3_data,
    output logic [bx_pkg::XLEN-1:0]  s3_pc,
    output logic                     s3_trap,
    input  logic                     s3_busy
);
    import bx_pkg::*;

    logic [4:0]      shamt;
    logic [XLEN-1:0] alu_res;

    assign shamt = s2_opr_b[4:0];                    // Low 5 bits only

    always_comb begin
        case (s2_uop)
            UOP_ADD, UOP_PASSB: alu_res = s2_opr_a + s2_opr_b;
            UOP_SUB:  alu_res = s2_opr_a - s2_opr_b;
            UOP_AND:  alu_res = s2_opr_a & s2_opr_b;
            UOP_OR:   alu_res = s2_opr_a | s2_opr_b;
            UOP_XOR:  alu_res = s2_opr_a ^ s2_opr_b;
            UOP_SLL:  alu_res = s2_opr_a << shamt;
            UOP_SRL:  alu_res = s2_opr_a >> shamt;
            UOP_SRA:  alu_res = $unsigned($signed(s2_opr_a) >>> shamt);
            UOP_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(s2_opr_a) < $signed(s2_opr_b)};
            UOP_SLTU: alu_res = {{(XLEN-1){1'b0}}, s2_opr_a < s2_opr_b};
            default:  alu_res = '0;
        endcase
    end

    // Producer seen by dispatch, hidden when empty or trapped
    assign fwd_s3_rd    = (s2_valid && !s2_trap) ? s2_rd : '0;
    assign fwd_s3_wdata = alu_res;

    // --------------------------------------------------
    // Stage register
    assign s2_busy = s3_valid && s3_busy;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s3_valid <= 1'b0;
        end else if (flush) begin
            s3_valid <= 1'b0;
        end else if (!s2_busy) begin
            s3_valid <= s2_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s2_valid && !s2_busy) begin
            s3_rd   <= s2_rd;
            s3_data <= alu_res;
            s3_pc   <= s2_pc;
            s3_trap <= s2_trap;
        end
    end

endmodule

//--- logic/bx_result.sv
// Result stage with retire register, register file write and forwarding export
`timescale 1ns/10ps
module bx_result (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     flush,
    input  logic                     s3_valid,
    input  logic [bx_pkg::REG_W-1:0] s3_rd,
    input  logic [bx_pkg::XLEN-1:0]  s3_data,
    input  logic [bx_pkg::XLEN-1:0]  s3_pc,
    input  logic                     s3_trap,
    output logic                     s3_busy,
    input  logic                     res_busy,       // Retire sink stall
    output logic [bx_pkg::REG_W-1:0] fwd_s4_rd,
    output logic [bx_pkg::XLEN-1:0]  fwd_s4_wdata,
    output logic                     gpr_wen,
    output logic [bx_pkg::REG_W-1:0] gpr_rd,
    output logic [bx_pkg::XLEN-1:0]  gpr_wdata,
    output logic                     ret_valid,
    output logic [bx_pkg::XLEN-1:0]  ret_pc,
    output logic [bx_pkg::REG_W-1:0] ret_rd,
    output logic [bx_pkg::XLEN-1:0]  ret_data,
    output logic                     ret_trap
);
    assign fwd_s4_rd    = (s3_valid && !s3_trap) ? s3_rd : '0;
    assign fwd_s4_wdata = s3_data;

    // Single write, on the retire transfer
    assign gpr_wen   = ret_valid && !res_busy && !ret_trap && (ret_rd != '0);
    assign gpr_rd    = ret_rd;
    assign gpr_wdata = ret_data;

    assign s3_busy = ret_valid && res_busy;

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_valid <= 1'b0;
        end else if (flush) begin
            ret_valid <= 1'b0;
        end else if (!s3_busy) begin
            ret_valid <= s3_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3_valid && !s3_busy) begin
            ret_pc   <= s3_pc;
            ret_rd   <= s3_rd;
            ret_data <= s3_data;
            ret_trap <= s3_trap;
        end
    end

endmodule

//--- logic/bx_backend.sv
// Backend top level joining decode, dispatch, execute and result stages
`timescale 1ns/10ps
module bx_backend (
    input  logic                     g_clk,
    input  logic                     rst_n,
    input  logic                     flush,          // Kill all in-flight work
    input  logic                     in_valid,
    input  bx_pkg::instr_u           in_instr,
    input  logic [bx_pkg::XLEN-1:0]  in_pc,
    output logic                     in_busy,
    input  logic                     res_busy,
    output logic                     ret_valid,
    output logic [bx_pkg::XLEN-1:0]  ret_pc,
    output logic [bx_pkg::REG_W-1:0] ret_rd,
    output logic [bx_pkg::XLEN-1:0]  ret_data,
    output logic                     ret_trap
);
    import bx_pkg::*;

    // --------------------------------------------------
    // Stage boundaries
    logic                 s1_valid, s1_busy, s1_trap;
    logic [REG_W-1:0]     s1_rd, s1_rs1, s1_rs2;
    logic [XLEN-1:0]      s1_imm, s1_pc;
    uop_e                 s1_uop;
    fu_e                  s1_fu;
    logic [OPR_SRC_W-1:0] s1_opr_src;
    logic                 s2_valid, s2_busy, s2_trap;
    logic [REG_W-1:0]     s2_rd;
    logic [XLEN-1:0]      s2_opr_a, s2_opr_b, s2_opr_c, s2_pc;
    uop_e                 s2_uop;
    logic                 s3_valid, s3_busy, s3_trap;
    logic [REG_W-1:0]     s3_rd;
    logic [XLEN-1:0]      s3_data, s3_pc;
    logic [REG_W-1:0]     fwd_s3_rd, fwd_s4_rd, gpr_rd;  // Forwarding and writeback
    logic [XLEN-1:0]      fwd_s3_wdata, fwd_s4_wdata, gpr_wdata;
    logic                 gpr_wen;

    bx_decode u_decode (
        .g_clk, .rst_n, .flush, .in_valid, .in_instr, .in_pc, .in_busy,
        .s1_valid, .s1_rd, .s1_rs1, .s1_rs2, .s1_imm, .s1_pc, .s1_uop, .s1_fu,
        .s1_trap, .s1_opr_src, .s1_busy
    );

    bx_dispatch u_dispatch (
        .g_clk, .rst_n, .flush,
        .s1_valid, .s1_rd, .s1_rs1, .s1_rs2, .s1_imm, .s1_pc, .s1_uop, .s1_fu,
        .s1_trap, .s1_opr_src, .s1_busy,
        .fwd_s3_rd, .fwd_s3_wdata, .fwd_s4_rd, .fwd_s4_wdata,
        .gpr_wen, .gpr_rd, .gpr_wdata,               // Register file write port
        .s2_valid, .s2_rd, .s2_opr_a, .s2_opr_b, .s2_opr_c, .s2_pc, .s2_uop,
        .s2_trap, .s2_busy
    );

    bx_execute u_execute (
        .g_clk, .rst_n, .flush,
        .s2_valid, .s2_rd, .s2_opr_a, .s2_opr_b, .s2_opr_c, .s2_pc, .s2_uop,
        .s2_trap, .s2_busy, .fwd_s3_rd, .fwd_s3_wdata,
        .s3_valid, .s3_rd, .s3_data, .s3_pc, .s3_trap, .s3_busy
    );

    bx_result u_result (
        .g_clk, .rst_n, .flush,
        .s3_valid, .s3_rd, .s3_data, .s3_pc, .s3_trap, .s3_busy, .res_busy,
        .fwd_s4_rd, .fwd_s4_wdata, .gpr_wen, .gpr_rd, .gpr_wdata,
        .ret_valid, .ret_pc, .ret_rd, .ret_data, .ret_trap
    );

endmodule

//--- bench/bx_backend_tb.sv
// Backend testbench with LFSR stimulus, reference model, retire compare and watchdog
`timescale 1ns/10ps
module bx_backend_tb;
    import bx_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int DRIVE_DLY  = 1;                   // Input skew after rising edge
    localparam int RST_CYCLES = 10;
    localparam int NUM_INSTR  = 400;                 // Directed prelude included

    logic        g_clk;
    logic        rst_n;
    logic        flush;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        in_busy;
    logic        res_busy;
    logic        ret_valid;
    logic [31:0] ret_pc;
    logic [4:0]  ret_rd;
    logic [31:0] ret_data;
    logic        ret_trap;

    logic [31:0] lfsr = 32'ha7ac;
    logic [31:0] model_regs [0:31];                  // Architectural state seen by the bench
    logic [31:0] pend_q [$];                         // Issued PCs, oldest first
    logic [31:0] instr_by_pc [logic [31:0]];
    logic [31:0] dir_q [$];                          // Directed words issued first
    int          issued = 0;

    bx_backend u_bx_backend (
        .g_clk, .rst_n, .flush, .in_valid, .in_instr, .in_pc, .in_busy, .res_busy,
        .ret_valid, .ret_pc, .ret_rd, .ret_data, .ret_trap
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    // --------------------------------------------------
    // Stimulus helpers
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};               // One step per bit
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        logic [31:0] r;
        if (rand_bits(3) == 0) begin
            r = rand_bits(5);                        // Anywhere in the file
            return r[4:0];
        end
        r = rand_bits(3);                            // x0..x7, dense dependences
        return {2'b00, r[2:0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] gen_instr();
        logic [31:0] kind;
        logic [31:0] f3;
        logic [31:0] imm;
        logic [31:0] sel;
        logic        alt_ok;
        kind   = rand_bits(4);
        f3     = rand_bits(3);
        imm    = rand_bits(20);
        sel    = rand_bits(1);
        alt_ok = (f3[2:0] == 3'b000 || f3[2:0] == 3'b101);  // SUB and SRA encodings
        if (kind < 7 || kind == 15) begin
            return enc_r((alt_ok && sel[0]) ? 7'h20 : 7'h00, pick_reg(), pick_reg(),
                         f3[2:0], pick_reg());
        end else if (kind < 12) begin
            if (f3[2:0] == 3'b001)
                imm[11:5] = 7'h00;                   // SLLI shamt only
            else if (f3[2:0] == 3'b101)
                imm[11:5] = sel[0] ? 7'h20 : 7'h00;
            return enc_i(imm[11:0], pick_reg(), f3[2:0], pick_reg(), OP_IMM);
        end else if (kind == 12) begin
            return {imm[19:0], pick_reg(), OP_LUI};
        end else if (kind == 13) begin
            return {imm[19:0], pick_reg(), OP_AUIPC};
        end
        return {imm[19:0], pick_reg(), sel[0] ? 7'b0000011 : 7'b1100011};  // Load or branch
    endfunction

    // --------------------------------------------------
    // Reference model and checks
    function automatic logic [31:0] ref_result(input logic [31:0] ins, input logic [31:0] pc,
                                               input logic [31:0] a, input logic [31:0] rs2_val,
                                               output logic trap);
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic        is_reg;
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_u  = {ins[31:12], 12'h000};
        is_reg = (ins[6:0] == OP_REG);
        b      = is_reg ? rs2_val : imm_i;
        trap   = 1'b0;
        if (ins[6:0] == OP_LUI)
            return imm_u;
        if (ins[6:0] == OP_AUIPC)
            return pc + imm_u;
        if (!is_reg && ins[6:0] != OP_IMM) begin
            trap = 1'b1;                             // Nothing else is implemented
            return '0;
        end
        case (ins[14:12])
            3'd0:    return (is_reg && ins[30]) ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("ERROR t=%0t %s", $time, why);
        $display("test failed");
        $fatal(1, "run aborted");
    endtask

    task automatic drop_in_flight();
        foreach (pend_q[k])
            instr_by_pc.delete(pend_q[k]);
        pend_q.delete();                             // These must never retire
    endtask

    // --------------------------------------------------
    // Driver
    initial begin : drive
        logic [31:0] cur_instr;
        logic [31:0] cur_pc;
        logic        took;
        foreach (model_regs[k])
            model_regs[k] = '0;
        rst_n    = 1'b0;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        res_busy = 1'b0;
        dir_q.push_back(enc_i(12'h7ff, 5'd0, 3'd0, 5'd1, OP_IMM));  // x1 = 2047
        dir_q.push_back(enc_i(12'h800, 5'd1, 3'd0, 5'd2, OP_IMM));  // Distance 1
        dir_q.push_back(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));      // Distances 1 and 2
        dir_q.push_back(enc_r(7'h00, 5'd3, 5'd1, 3'd0, 5'd4));      // Distances 1 and 3
        dir_q.push_back(enc_r(7'h00, 5'd4, 5'd4, 3'd0, 5'd0));      // x0 destination
        dir_q.push_back(enc_r(7'h00, 5'd0, 5'd4, 3'd7, 5'd5));      // x0 source
        dir_q.push_back({20'h12345, 5'd6, OP_LUI});
        dir_q.push_back({20'hfffff, 5'd7, OP_AUIPC});
        dir_q.push_back(enc_i(12'h000, 5'd0, 3'd2, 5'd1, 7'b0000011));  // Trap on x1
        dir_q.push_back(enc_r(7'h00, 5'd0, 5'd1, 3'd0, 5'd2));      // x1 still intact
        repeat (RST_CYCLES) @(posedge g_clk);
        #DRIVE_DLY;
        rst_n     = 1'b1;
        cur_pc    = 32'h0000_1000;
        cur_instr = dir_q.pop_front();
        in_instr  = cur_instr;
        in_pc     = cur_pc;
        in_valid  = 1'b1;
        while (issued < NUM_INSTR) begin
            @(negedge g_clk);
            took = in_valid && !in_busy && !flush;  // Transfer on the coming edge
            @(posedge g_clk);
            #DRIVE_DLY;
            if (took) begin
                pend_q.push_back(cur_pc);
                instr_by_pc[cur_pc] = cur_instr;
                issued++;
                cur_pc    = cur_pc + 32'd4;
                cur_instr = (dir_q.size() != 0) ? dir_q.pop_front() : gen_instr();
            end
            if (flush) begin
                drop_in_flight();
                flush = 1'b0;
            end
            if (dir_q.size() == 0 && pend_q.size() != 0 && rand_bits(6) == 0) begin
                flush    = 1'b1;                     // Sink held so nothing retires
                in_valid = 1'b0;
                res_busy = 1'b1;
            end else begin
                res_busy = (rand_bits(2) == 0);
                in_instr = cur_instr;
                in_pc    = cur_pc;
                in_valid = 1'b1;
            end
        end
        in_valid = 1'b0;
        if (flush) begin                            // Flush raised on the last pass
            @(posedge g_clk);
            #DRIVE_DLY;
            drop_in_flight();
            flush = 1'b0;
        end
        while (pend_q.size() != 0) begin            // Drain under random stalls
            @(posedge g_clk);
            #DRIVE_DLY;
            res_busy = (rand_bits(2) == 0);
        end
        res_busy = 1'b0;
        repeat (8) @(posedge g_clk);                // Catch stray retires
        $display("test passed");
        $finish;
    end

    // --------------------------------------------------
    // Retire compare
    initial begin : compare
        logic [31:0] ins;
        logic [31:0] exp_pc;
        logic [31:0] exp_data;
        logic        exp_trap;
        forever begin
            @(negedge g_clk);                        // Outputs settled mid cycle
            if (rst_n && ret_valid && !res_busy) begin
                if (pend_q.size() == 0 || !instr_by_pc.exists(ret_pc)) begin
                    abort_run("an instruction retired that was never issued or was flushed");
                end else begin
                    exp_pc = pend_q.pop_front();
                    check_value("ret_pc", ret_pc, exp_pc);
                    ins      = instr_by_pc[ret_pc];
                    exp_data = ref_result(ins, ret_pc, model_regs[ins[19:15]],
                                          model_regs[ins[24:20]], exp_trap);
                    check_value("ret_trap", ret_trap, exp_trap);
                    check_value("ret_rd", ret_rd, ins[11:7]);
                    if (!exp_trap) begin
                        check_value("ret_data", ret_data, exp_data);
                        if (ins[11:7] != 5'd0)
                            model_regs[ins[11:7]] = exp_data;
                    end
                    instr_by_pc.delete(ret_pc);
                end
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (RST_CYCLES + NUM_INSTR * 20));
        $display("ERROR t=%0t timeout, the pipeline did not retire everything in time", $time);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- filelist.f
logic/bx_pkg.sv
logic/bx_gprs.sv
logic/bx_decode.sv
logic/bx_dispatch.sv
logic/bx_execute.sv
logic/bx_result.sv
logic/bx_backend.sv
bench/bx_backend_tb.sv

//--- Bender.yml
package:
  name: bx_backend

sources:
  - files:
      - logic/bx_pkg.sv
      - logic/bx_gprs.sv
      - logic/bx_decode.sv
      - logic/bx_dispatch.sv
      - logic/bx_execute.sv
      - logic/bx_result.sv
      - logic/bx_backend.sv
  - target: simulation
    files:
      - bench/bx_backend_tb.sv
